//--- tb/rv_core_tests.hex
// Record: instruction count, instructions, store count, address/data pairs, end code
// End code 1 means ebreak and 2 means trap; a zero count closes the file
// test_0 ALU register and immediate operations
0000001B
FF900093 00300113 002081B3 40208233 0020A2B3 0020B333 4020D3B3 0020D433
002094B3 0020C533 0F00F593 10016613 4010D693 FFA0A713
10302023 10402223 10502423 10602623 10702823 10802A23 10902C23 10A02E23
12B02023 12C02223 12D02423 12E02623 00100073
0000000C
00000100 FFFFFFFC 00000104 FFFFFFF6 00000108 00000001 0000010C 00000000
00000110 FFFFFFFF 00000114 1FFFFFFF 00000118 FFFFFFC8 0000011C FFFFFFFA
00000120 000000F0 00000124 00000103 00000128 FFFFFFFC 0000012C 00000001
00000001
// test_1 load path, x0 writes, LUI and AUIPC
0000000D
05500093 10102023 10002103 00110193 10302223 00500013 00108033 10002423
12345237 10402623 00001297 10502823 00100073
00000005
00000100 00000055 00000104 00000056 00000108 00000000 0000010C 12345000
00000110 00001028
00000001
// test_2 branches taken over bad stores, not taken into good stores
0000001C
FFF00093 00100113 00210463 1E102823 00208463 10202023 00209463 1E102823
00211463 10202223 0020C463 1E102823 00114463 10202423 00115463 1E102823
0020D463 10202623 00116463 1E102823 0020E463 10202823 0020F463 1E102823
00117463 10202A23 00100073 1E102823
00000006
00000100 00000001 00000104 00000001 00000108 00000001 0000010C 00000001
00000110 00000001 00000114 00000001
00000001
// test_3 JAL and JALR link values
00000009
008000EF 1E102823 10102023 01C00313 001303E7 1E102823 1E102823 10702223
00100073
00000002
00000100 00000004 00000104 00000014
00000001
// test_4 illegal opcode, then test_5 ECALL
00000005
07700093 10102023 FFFFFFFF 1E102823 00100073
00000001
00000100 00000077
00000002
00000002
00000073 1E102823
00000000
00000002
00000000

//--- vlog.f
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_fetch.sv
src/rv_core.sv
tb/rv_clock_gen.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TOP        ?= rv_core_tb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --timing
VFLAGS     ?= --binary --timing --assert
PASS_MSG   ?= ** PASS **

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- tb/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb
  import rv_pkg::*;
();

  localparam int    IMEM_WORDS = 64;
  localparam int    DMEM_WORDS = 256;
  localparam int    TEST_WORDS = 1024;
  localparam string TEST_FILE  = "tb/rv_core_tests.hex";
  localparam word_t IDLE_WORD  = '1;

  logic  clk;
  logic  rst_n;
  logic  imem_arvalid;
  word_t imem_araddr;
  word_t imem_rdata;
  logic  dmem_ren;
  word_t dmem_raddr;
  word_t dmem_rdata;
  logic  dmem_we;
  word_t dmem_waddr;
  word_t dmem_wdata;
  logic  ebreak;
  logic  trap;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t test_data [TEST_WORDS];
  word_t exp_addr [$];
  word_t exp_data [$];
  string test_name;
  int    stores_seen;
  int    mismatch_errors;
  int    other_errors;
  int    cycle_count;
  int    cycle_limit;

  rv_clock_gen clock_gen_i (
    .clk(clk)
  );

  rv_core rv_core_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_arvalid(imem_arvalid),
    .imem_araddr (imem_araddr),
    .imem_rdata  (imem_rdata),
    .dmem_ren    (dmem_ren),
    .dmem_raddr  (dmem_raddr),
    .dmem_rdata  (dmem_rdata),
    .dmem_we     (dmem_we),
    .dmem_waddr  (dmem_waddr),
    .dmem_wdata  (dmem_wdata),
    .ebreak      (ebreak),
    .trap        (trap)
  );

  bind rv_core rv_core_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ebreak      (ebreak),
    .trap        (trap),
    .dmem_we     (dmem_we),
    .imem_arvalid(imem_arvalid),
    .imem_araddr (imem_araddr)
  );

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  // Idle ports read as all ones
  assign imem_rdata = imem_arvalid ? imem[imem_araddr[7:2]] : IDLE_WORD;
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : IDLE_WORD;

  always @(posedge clk) begin
    if (rst_n && dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
      check_store(dmem_waddr, dmem_wdata);
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      other_errors++;
      $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
      report_counts();
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
      mismatch_errors++;
    end
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    if (stores_seen < exp_addr.size()) begin
      check_word("store address", exp_addr[stores_seen], addr);
      check_word("store data", exp_data[stores_seen], data);
    end else begin
      $display("%s: unexpected store of %h to address %h", test_name, data, addr);
      other_errors++;
    end
    stores_seen++;
  endtask

  task automatic clear_memories();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] <= '0;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
  endtask

  // Twice the instruction total plus 20 cycles per test
  function automatic int cycle_budget();
    int ptr;
    int n_instr;
    int total;
    int n_tests;
    ptr = 0;
    total = 0;
    n_tests = 0;
    while (ptr < TEST_WORDS && test_data[ptr] != '0) begin
      n_instr = int'(test_data[ptr]);
      total += n_instr;
      n_tests++;
      ptr += n_instr + 1;
      ptr += 2 * int'(test_data[ptr]) + 2;
    end
    return 2 * total + 20 * n_tests;
  endfunction

  // ----------------------------------------
  // One test record
  // ----------------------------------------
  task automatic run_test(input int idx, inout int ptr);
    int    n_instr;
    int    n_stores;
    word_t exp_end;
    n_instr = int'(test_data[ptr]);
    ptr++;
    clear_memories();
    for (int i = 0; i < n_instr; i++) begin
      imem[i] = test_data[ptr + i];
    end
    ptr += n_instr;
    n_stores = int'(test_data[ptr]);
    ptr++;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < n_stores; i++) begin
      exp_addr.push_back(test_data[ptr + 2 * i]);
      exp_data.push_back(test_data[ptr + 2 * i + 1]);
    end
    ptr += 2 * n_stores;
    exp_end = test_data[ptr];
    ptr++;
    test_name = $sformatf("test_%0d", idx);
    stores_seen = 0;

    apply_reset();
    while (!(ebreak || trap)) begin
      @(negedge clk);
    end
    // A couple of extra cycles so a store after the halt would show up
    repeat (2) @(negedge clk);

    check_word("end code", exp_end, {30'b0, trap, ebreak});
    if (stores_seen != n_stores) begin
      $display("%s: expected %0d stores, saw %0d", test_name, n_stores, stores_seen);
      other_errors++;
    end
  endtask

  initial begin
    int ptr;
    int test_idx;
    rst_n <= 1'b0;
    cycle_count = 0;
    cycle_limit = 0;
    mismatch_errors = 0;
    other_errors = 0;
    stores_seen = 0;
    test_name = "reset";
    clear_memories();
    $readmemh(TEST_FILE, test_data);
    cycle_limit = cycle_budget();

    ptr = 0;
    test_idx = 0;
    while (ptr < TEST_WORDS && test_data[ptr] != '0) begin
      run_test(test_idx, ptr);
      test_idx++;
    end

    report_counts();
    if (mismatch_errors + other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb/rv_core_props.sv
`timescale 1ns/100ps

module rv_core_props
  import rv_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  ebreak,
  input logic  trap,
  input logic  dmem_we,
  input logic  imem_arvalid,
  input word_t imem_araddr
);

  // Halted core neither fetches nor stores
  halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (ebreak || trap) |-> (!dmem_we && !imem_arvalid))
    else $error("core fetched or stored while halted");

  // Status flags only clear through reset
  ebreak_sticky: assert property (@(posedge clk) $fell(ebreak) |-> !$past(rst_n))
    else $error("ebreak dropped without reset");

  trap_sticky: assert property (@(posedge clk) $fell(trap) |-> !$past(rst_n))
    else $error("trap dropped without reset");

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_araddr[1:0] == 2'b00)
    else $error("instruction address %h not word aligned", imem_araddr);

endmodule

//--- tb/rv_clock_gen.sv
`timescale 1ns/100ps

module rv_clock_gen (
  output logic clk
);

  // Half of the 8 ns period
  localparam int HALF_PERIOD = 4;

  initial begin
    clk = 1'b0;
  end

  always begin
    #HALF_PERIOD clk = ~clk;
  end

endmodule

//--- src/rv_core.sv
`timescale 1ns/100ps

module rv_core
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  // Instruction memory, answers in the same cycle
  output logic  imem_arvalid,
  output word_t imem_araddr,
  input  word_t imem_rdata,

  // Data memory read
  output logic  dmem_ren,
  output word_t dmem_raddr,
  input  word_t dmem_rdata,

  // Data memory write, captured on the rising edge
  output logic  dmem_we,
  output word_t dmem_waddr,
  output word_t dmem_wdata,

  output logic  ebreak,
  output logic  trap
);

  word_t      pc;
  word_t      pc_plus4;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm;
  alu_op_t    alu_op;
  alu_op_t    alu_op_sel;
  a_src_t     a_src;
  logic       b_imm;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  res_src_t   res_src;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic [2:0] funct3;
  logic       is_ebreak;
  logic       illegal;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic       branch_cond;
  word_t      wb_data;
  logic       halt;

  assign halt = ebreak || trap;

  rv_fetch fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .halt       (halt),
    .is_branch  (is_branch),
    .branch_cond(branch_cond),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .pc         (pc),
    .pc_plus4   (pc_plus4)
  );

  rv_decoder decoder_i (
    .instr    (imem_rdata),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .alu_op   (alu_op),
    .a_src    (a_src),
    .b_imm    (b_imm),
    .reg_write(reg_write),
    .mem_read (mem_read),
    .mem_write(mem_write),
    .res_src  (res_src),
    .is_branch(is_branch),
    .is_jal   (is_jal),
    .is_jalr  (is_jalr),
    .funct3   (funct3),
    .is_ebreak(is_ebreak),
    .illegal  (illegal)
  );

  rv_regfile regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .we      (reg_write && !halt),
    .rd      (rd),
    .wdata   (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // ----------------------------------------
  // Operand muxes and ALU
  // ----------------------------------------
  always_comb begin
    case (a_src)
      A_PC:    alu_a = pc;
      A_ZERO:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = b_imm ? imm : rs2_data;

  // Address generation and AUIPC always add
  assign alu_op_sel = (mem_read || mem_write || (a_src == A_PC)) ? ALU_ADD : alu_op;

  rv_alu alu_i (
    .op         (alu_op_sel),
    .a          (alu_a),
    .b          (alu_b),
    .funct3     (funct3),
    .result     (alu_result),
    .branch_cond(branch_cond)
  );

  // ----------------------------------------
  // Memory ports and write-back
  // ----------------------------------------
  assign imem_arvalid = !halt;
  assign imem_araddr  = pc;

  assign dmem_ren   = mem_read && !halt;
  assign dmem_raddr = alu_result;
  assign dmem_we    = mem_write && !halt;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;

  always_comb begin
    case (res_src)
      RES_MEM: wb_data = dmem_rdata;
      RES_PC4: wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // Sticky status, held until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      ebreak <= ebreak || (is_ebreak && !halt);
      trap   <= trap || (illegal && !halt);
    end
  end

endmodule

//--- src/rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  halt,
  input  logic  is_branch,
  input  logic  branch_cond,
  input  logic  is_jal,
  input  logic  is_jalr,
  input  word_t imm,
  input  word_t rs1_data,
  output word_t pc,
  output word_t pc_plus4
);

  word_t pc_rel_tgt;
  word_t jalr_tgt;
  word_t pc_next;

  assign pc_plus4   = pc + word_t'(4);
  assign pc_rel_tgt = pc + imm;

  // JALR clears bit 0 of the computed target
  assign jalr_tgt = (rs1_data + imm) & ~word_t'(1);

  always_comb begin
    if (is_jalr) begin
      pc_next = jalr_tgt;
    end else if (is_jal || (is_branch && branch_cond)) begin
      pc_next = pc_rel_tgt;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halt) begin
      pc <= pc_next;
    end
  end

endmodule

//--- src/rv_alu.sv
`timescale 1ns/100ps

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_t    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [2:0] funct3,
  output word_t      result,
  output logic       branch_cond
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal       = (a == b);

  // ----------------------------------------
  // Arithmetic and logic
  // ----------------------------------------
  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      default:  result = '0;
    endcase
  end

  // ----------------------------------------
  // Branch comparator on rs1/rs2
  // ----------------------------------------
  always_comb begin
    case (funct3)
      F3_BEQ:  branch_cond = equal;
      F3_BNE:  branch_cond = !equal;
      F3_BLT:  branch_cond = lt_signed;
      F3_BGE:  branch_cond = !lt_signed;
      F3_BLTU: branch_cond = lt_unsigned;
      F3_BGEU: branch_cond = !lt_unsigned;
      default: branch_cond = 1'b0;
    endcase
  end

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     wdata,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder
  import rv_pkg::*;
(
  input  word_t      instr,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output word_t      imm,
  output alu_op_t    alu_op,
  output a_src_t     a_src,
  output logic       b_imm,
  output logic       reg_write,
  output logic       mem_read,
  output logic       mem_write,
  output res_src_t   res_src,
  output logic       is_branch,
  output logic       is_jal,
  output logic       is_jalr,
  output logic [2:0] funct3,
  output logic       is_ebreak,
  output logic       illegal
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       alt_op;
  alu_op_t    arith_op;

  // Field extraction
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // SUB needs R-type, SRA/SRAI use the same bit in both formats
  assign alt_op = funct7[5] && ((opcode == OP_RTYPE) || (funct3 == 3'b101));

  always_comb begin
    case (funct3)
      3'b000:  arith_op = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // ----------------------------------------
  // Control and immediate decode
  // ----------------------------------------
  always_comb begin
    imm       = '0;
    alu_op    = ALU_ADD;
    a_src     = A_RS1;
    b_imm     = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    res_src   = RES_ALU;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;

    case (opcode)
      OP_LUI: begin
        imm       = {instr[31:12], 12'b0};
        a_src     = A_ZERO;
        b_imm     = 1'b1;
        reg_write = 1'b1;
      end
      OP_AUIPC: begin
        imm       = {instr[31:12], 12'b0};
        a_src     = A_PC;
        b_imm     = 1'b1;
        reg_write = 1'b1;
      end
      OP_JAL: begin
        imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        is_jal    = 1'b1;
        reg_write = 1'b1;
        res_src   = RES_PC4;
      end
      OP_JALR: begin
        imm       = {{20{instr[31]}}, instr[31:20]};
        is_jalr   = 1'b1;
        reg_write = 1'b1;
        res_src   = RES_PC4;
      end
      OP_BRANCH: begin
        imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        is_branch = 1'b1;
        illegal   = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OP_LOAD: begin
        imm       = {{20{instr[31]}}, instr[31:20]};
        b_imm     = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
        res_src   = RES_MEM;
        illegal   = (funct3 != 3'b010);
      end
      OP_STORE: begin
        imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        b_imm     = 1'b1;
        mem_write = 1'b1;
        illegal   = (funct3 != 3'b010);
      end
      OP_IMM: begin
        imm       = {{20{instr[31]}}, instr[31:20]};
        b_imm     = 1'b1;
        alu_op    = arith_op;
        reg_write = 1'b1;
      end
      OP_RTYPE: begin
        alu_op    = arith_op;
        reg_write = 1'b1;
        illegal   = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      OP_SYSTEM: begin
        is_ebreak = (instr == INSTR_EBREAK);
        illegal   = (instr != INSTR_EBREAK);
      end
      default: illegal = 1'b1;
    endcase

    // An illegal instruction must leave no side effects
    if (illegal) begin
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
    end
  end

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

  // ----------------------------------------
  // Widths and basic types
  // ----------------------------------------
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  // ----------------------------------------
  // ALU operation selector
  // ----------------------------------------
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLT  = 4'd5;
  localparam alu_op_t ALU_SLTU = 4'd6;
  localparam alu_op_t ALU_SLL  = 4'd7;
  localparam alu_op_t ALU_SRL  = 4'd8;
  localparam alu_op_t ALU_SRA  = 4'd9;

  // Write-back source
  typedef logic [1:0] res_src_t;

  localparam res_src_t RES_ALU = 2'd0;
  localparam res_src_t RES_MEM = 2'd1;
  localparam res_src_t RES_PC4 = 2'd2;

  // ALU operand A source
  typedef logic [1:0] a_src_t;

  localparam a_src_t A_RS1  = 2'd0;
  localparam a_src_t A_PC   = 2'd1;
  localparam a_src_t A_ZERO = 2'd2;

  // ----------------------------------------
  // RV32I opcodes
  // ----------------------------------------
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Branch conditions in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Start address and the one SYSTEM encoding that is accepted
  localparam word_t RESET_PC     = 32'h0000_0000;
  localparam word_t INSTR_EBREAK = 32'h0010_0073;

endpackage
